// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := download_tb
FILELIST := list.f
OBJDIR   := obj_dir
PASS_MSG := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run $(TOP)"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== include/dl_macros.svh ====
`ifndef DL_MACROS_SVH
`define DL_MACROS_SVH

// **************************************************
// table sizes
// **************************************************

// records read from the config image, at most.
`define MAX_CONFIG    16

// entries in the memory block table.
`define MAX_MEM_BLOCK 16

// **************************************************
// ddr3 staging area
// **************************************************

// header byte, records follow at +1.
`define CONFIG_BASE   28'h0100000

// page 0 of the staged rom images.
`define ROM_BASE      28'h0200000

// allocation and copy granule in bytes.
`define PAGE_BYTES    256

`endif

// ==== list.f ====
+incdir+include
rtl/msx_pkg.sv
rtl/dl_pkg.sv
rtl/download_rom.sv
rtl/download_config.sv
rtl/download_msx.sv
rtl/download.sv
verif/download_assertions.sv
verif/download_tb.sv

// ==== rtl/dl_pkg.sv ====
`default_nettype none

package dl_pkg;

   // kind bit of a record, the top bit of the word.
   localparam logic KIND_BLOCK = 1'b1;

   // first byte of the config image.
   typedef struct packed {
      logic       spare;
      logic [4:0] count;      // records that follow.
      logic [1:0] msx_type;
   } config_hdr_t;

   // **************************************************
   // record views
   // **************************************************

   typedef struct packed {
      logic       kind;       // 1 here.
      logic       ram;
      logic [3:0] block_id;
      logic [9:0] src_page;   // from ROM_BASE.
      logic [7:0] size_pages;
      logic [7:0] reserved;
   } cfg_block_t;

   typedef struct packed {
      logic        kind;      // 0 here.
      logic [1:0]  slot;
      logic [1:0]  subslot;
      logic        expanded;
      logic [15:0] page_block;
      logic [9:0]  reserved;
   } cfg_slot_t;

   // one 32 bit record, decoded by its kind bit.
   typedef union packed {
      cfg_block_t block;
      cfg_slot_t  slot;
   } msx_config_u;

endpackage

`default_nettype wire

// ==== rtl/download.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dl_macros.svh"

module download (
   input  logic               clk,
   input  logic               rst,
   input  logic               ioctl_download,
   input  logic [15:0]        ioctl_index,
   input  logic [26:0]        ioctl_addr,
   input  logic               rom_eject,
   output logic [27:0]        ddr3_addr,
   output logic               ddr3_rd,
   input  logic [7:0]         ddr3_dout,
   input  logic               ddr3_ready,
   output logic               ddr3_request,
   input  logic               sdram_ready,
   output logic               sdram_request,
   output logic [24:0]        sdram_addr,
   output logic [7:0]         sdram_din,
   output logic               sdram_we,
   output msx_pkg::block_t    memory_block [`MAX_MEM_BLOCK],
   output msx_pkg::slot_t     msx_slot [4],
   output msx_pkg::rom_info_t rom_info [2],
   output logic [1:0]         msx_type,
   output logic [7:0]         ram_block_count,
   output logic               need_reset
);

   import dl_pkg::*;

   logic        rom_update;
   logic        cfg_update;
   logic        update_request;
   logic [27:0] cfg_ddr3_addr;
   logic        cfg_ddr3_rd;
   logic        cfg_ddr3_request;
   logic [27:0] msx_ddr3_addr;
   logic        msx_ddr3_rd;
   logic        msx_ddr3_request;
   logic [4:0]  record_count;
   msx_config_u msx_config [`MAX_CONFIG];

   // config reader owns ddr3 while it runs.
   assign ddr3_addr      = cfg_ddr3_request ? cfg_ddr3_addr : msx_ddr3_addr;
   assign ddr3_rd        = cfg_ddr3_request ? cfg_ddr3_rd : msx_ddr3_rd;
   assign ddr3_request   = cfg_ddr3_request | msx_ddr3_request;
   assign update_request = cfg_update | rom_update;

   download_rom download_rom (
      .clk            (clk),
      .rst            (rst),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_addr     (ioctl_addr),
      .rom_eject      (rom_eject),
      .rom_info       (rom_info),
      .rom_update     (rom_update)
   );

   download_config download_config (
      .clk            (clk),
      .rst            (rst),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ddr3_dout      (ddr3_dout),
      .ddr3_ready     (ddr3_ready),
      .ddr3_addr      (cfg_ddr3_addr),
      .ddr3_rd        (cfg_ddr3_rd),
      .ddr3_request   (cfg_ddr3_request),
      .msx_config     (msx_config),
      .record_count   (record_count),
      .msx_type       (msx_type),
      .cfg_update     (cfg_update)
   );

   download_msx download_msx (
      .clk             (clk),
      .rst             (rst),
      .update_request  (update_request),
      .msx_config      (msx_config),
      .record_count    (record_count),
      .ddr3_dout       (ddr3_dout),
      .ddr3_ready      (ddr3_ready),
      .sdram_ready     (sdram_ready),
      .ddr3_addr       (msx_ddr3_addr),
      .ddr3_rd         (msx_ddr3_rd),
      .ddr3_request    (msx_ddr3_request),
      .sdram_request   (sdram_request),
      .sdram_addr      (sdram_addr),
      .sdram_din       (sdram_din),
      .sdram_we        (sdram_we),
      .memory_block    (memory_block),
      .msx_slot        (msx_slot),
      .ram_block_count (ram_block_count),
      .need_reset      (need_reset)
   );

endmodule

`default_nettype wire

// ==== rtl/download_config.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dl_macros.svh"

module download_config (
   input  logic                clk,
   input  logic                rst,
   input  logic                ioctl_download,
   input  logic [15:0]         ioctl_index,
   input  logic [7:0]          ddr3_dout,
   input  logic                ddr3_ready,
   output logic [27:0]         ddr3_addr,
   output logic                ddr3_rd,
   output logic                ddr3_request,
   output dl_pkg::msx_config_u msx_config [`MAX_CONFIG],
   output logic [4:0]          record_count,
   output logic [1:0]          msx_type,
   output logic                cfg_update
);

   import dl_pkg::*;

   typedef enum logic [1:0] {IDLE, HDR_WAIT, REC_WAIT} state_t;

   state_t      state;
   logic        dl_q;
   logic        start;
   config_hdr_t hdr;
   logic [4:0]  hdr_count;
   logic [4:0]  total;
   logic [1:0]  type_q;
   logic [3:0]  rec_idx;
   logic [1:0]  byte_sel;
   logic [23:0] rec_lo;
   logic        last_byte;

   assign start     = dl_q & ~ioctl_download & (ioctl_index == 16'd0);
   assign hdr       = config_hdr_t'(ddr3_dout);
   assign hdr_count = (hdr.count > 5'(`MAX_CONFIG)) ? 5'(`MAX_CONFIG) : hdr.count;
   assign last_byte = (byte_sel == 2'd3) && ({1'b0, rec_idx} == total - 5'd1);

   // **************************************************
   // read sequencer
   // **************************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         state        <= IDLE;
         dl_q         <= 1'b0;
         ddr3_rd      <= 1'b0;
         ddr3_request <= 1'b0;
         cfg_update   <= 1'b0;
         record_count <= '0;
         msx_type     <= '0;
         total        <= '0;
         type_q       <= '0;
         rec_idx      <= '0;
         byte_sel     <= '0;
      end else begin
         dl_q       <= ioctl_download;
         ddr3_rd    <= 1'b0;
         cfg_update <= 1'b0;
         case (state)
            IDLE: begin
               if (start) begin
                  ddr3_request <= 1'b1;
                  ddr3_rd      <= 1'b1;   // header byte.
                  state        <= HDR_WAIT;
               end
            end
            HDR_WAIT: begin
               if (ddr3_ready) begin
                  total    <= hdr_count;
                  type_q   <= hdr.msx_type;
                  rec_idx  <= '0;
                  byte_sel <= '0;
                  if (hdr_count == 5'd0) begin   // empty image.
                     ddr3_request <= 1'b0;
                     cfg_update   <= 1'b1;
                     msx_type     <= hdr.msx_type;
                     record_count <= '0;
                     state        <= IDLE;
                  end else begin
                     ddr3_rd <= 1'b1;
                     state   <= REC_WAIT;
                  end
               end
            end
            REC_WAIT: begin
               if (ddr3_ready) begin
                  byte_sel <= byte_sel + 2'd1;
                  if (byte_sel == 2'd3) rec_idx <= rec_idx + 4'd1;
                  if (last_byte) begin
                     ddr3_request <= 1'b0;
                     cfg_update   <= 1'b1;
                     msx_type     <= type_q;
                     record_count <= total;
                     state        <= IDLE;
                  end else begin
                     ddr3_rd <= 1'b1;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // address and record assembly, little endian.
   always_ff @(posedge clk) begin
      if (state == IDLE && start) ddr3_addr <= `CONFIG_BASE;
      else if (state != IDLE && ddr3_ready) ddr3_addr <= ddr3_addr + 28'd1;

      if (state == REC_WAIT && ddr3_ready) begin
         if (byte_sel == 2'd3) msx_config[rec_idx] <= {ddr3_dout, rec_lo};
         else rec_lo[{byte_sel, 3'b000} +: 8] <= ddr3_dout;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/download_msx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dl_macros.svh"

module download_msx (
   input  logic                clk,
   input  logic                rst,
   input  logic                update_request,
   input  dl_pkg::msx_config_u msx_config [`MAX_CONFIG],
   input  logic [4:0]          record_count,
   input  logic [7:0]          ddr3_dout,
   input  logic                ddr3_ready,
   input  logic                sdram_ready,
   output logic [27:0]         ddr3_addr,
   output logic                ddr3_rd,
   output logic                ddr3_request,
   output logic                sdram_request,
   output logic [24:0]         sdram_addr,
   output logic [7:0]          sdram_din,
   output logic                sdram_we,
   output msx_pkg::block_t     memory_block [`MAX_MEM_BLOCK],
   output msx_pkg::slot_t      msx_slot [4],
   output logic [7:0]          ram_block_count,
   output logic                need_reset
);

   import dl_pkg::*;
   import msx_pkg::*;

   typedef enum logic [1:0] {IDLE, WALK, RD_WAIT, WR_WAIT} state_t;

   state_t      state;
   logic        pending;
   logic [4:0]  rec_idx;
   logic [11:0] page_cnt;   // next free sdram page.
   logic [15:0] copy_left;
   msx_config_u rec;
   block_t      blk_entry;
   slot_t       slot_entry;
   logic        walk_done;
   logic        is_block;

   assign rec        = msx_config[rec_idx[3:0]];
   assign walk_done  = (rec_idx == record_count);
   assign is_block   = (rec.block.kind == KIND_BLOCK);
   assign blk_entry  = '{valid: 1'b1, ram: rec.block.ram, sdram_page: page_cnt,
                         size_pages: rec.block.size_pages};
   assign slot_entry = '{expanded: rec.slot.expanded, page_block: rec.slot.page_block};

   // **************************************************
   // record walk and copy control
   // **************************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         state           <= IDLE;
         pending         <= 1'b0;
         rec_idx         <= '0;
         page_cnt        <= '0;
         ram_block_count <= '0;
         ddr3_rd         <= 1'b0;
         ddr3_request    <= 1'b0;
         sdram_request   <= 1'b0;
         sdram_we        <= 1'b0;
         need_reset      <= 1'b0;
         for (int i = 0; i < `MAX_MEM_BLOCK; i++) memory_block[i] <= '0;
         for (int i = 0; i < 4; i++) msx_slot[i] <= '0;
      end else begin
         ddr3_rd    <= 1'b0;
         sdram_we   <= 1'b0;
         need_reset <= 1'b0;
         if (update_request) pending <= 1'b1;
         case (state)
            IDLE: begin
               if (pending) begin
                  pending         <= update_request;   // keep a request from this cycle.
                  rec_idx         <= '0;
                  page_cnt        <= '0;
                  ram_block_count <= '0;
                  for (int i = 0; i < `MAX_MEM_BLOCK; i++) memory_block[i] <= '0;
                  for (int i = 0; i < 4; i++) msx_slot[i] <= '0;
                  state <= WALK;
               end
            end
            WALK: begin
               if (walk_done) begin
                  need_reset <= 1'b1;
                  state      <= IDLE;
               end else if (is_block) begin
                  memory_block[rec.block.block_id] <= blk_entry;
                  page_cnt <= page_cnt + 12'(rec.block.size_pages);
                  if (rec.block.ram) ram_block_count <= ram_block_count + 8'd1;
                  if (rec.block.ram || rec.block.size_pages == 8'd0) begin
                     rec_idx <= rec_idx + 5'd1;   // nothing to copy.
                  end else begin
                     ddr3_request  <= 1'b1;
                     sdram_request <= 1'b1;
                     ddr3_rd       <= 1'b1;
                     state         <= RD_WAIT;
                  end
               end else begin
                  msx_slot[rec.slot.slot] <= slot_entry;
                  rec_idx <= rec_idx + 5'd1;
               end
            end
            RD_WAIT: begin
               if (ddr3_ready) begin
                  sdram_we <= 1'b1;
                  state    <= WR_WAIT;
               end
            end
            WR_WAIT: begin
               if (sdram_ready) begin
                  if (copy_left == 16'd1) begin
                     ddr3_request  <= 1'b0;
                     sdram_request <= 1'b0;
                     rec_idx       <= rec_idx + 5'd1;
                     state         <= WALK;
                  end else begin
                     ddr3_rd <= 1'b1;
                     state   <= RD_WAIT;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // copy pointers.
   always_ff @(posedge clk) begin
      if (state == WALK && !walk_done && is_block) begin
         ddr3_addr  <= 28'(`ROM_BASE + rec.block.src_page * `PAGE_BYTES);
         sdram_addr <= 25'(page_cnt * `PAGE_BYTES);
         copy_left  <= 16'(rec.block.size_pages * `PAGE_BYTES);
      end
      if (state == RD_WAIT && ddr3_ready) sdram_din <= ddr3_dout;
      if (state == WR_WAIT && sdram_ready) begin
         ddr3_addr  <= ddr3_addr + 28'd1;
         sdram_addr <= sdram_addr + 25'd1;
         copy_left  <= copy_left - 16'd1;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/download_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module download_rom (
   input  logic               clk,
   input  logic               rst,
   input  logic               ioctl_download,
   input  logic [15:0]        ioctl_index,
   input  logic [26:0]        ioctl_addr,
   input  logic               rom_eject,
   output msx_pkg::rom_info_t rom_info [2],
   output logic               rom_update
);

   logic        dl_q;
   logic        eject_q;
   logic [15:0] index_q;
   logic [26:0] last_addr;
   logic        dl_end;
   logic        eject_rise;
   logic        cart_end;

   assign dl_end     = dl_q & ~ioctl_download;
   assign eject_rise = rom_eject & ~eject_q;
   assign cart_end   = dl_end && (index_q == 16'd1 || index_q == 16'd2);   // cartridge a or b.

   always_ff @(posedge clk) begin
      if (rst) begin
         dl_q    <= 1'b0;
         eject_q <= 1'b0;
      end else begin
         dl_q    <= ioctl_download;
         eject_q <= rom_eject;
      end
   end

   // last address seen while the transfer runs.
   always_ff @(posedge clk) begin
      if (ioctl_download) begin
         index_q   <= ioctl_index;
         last_addr <= ioctl_addr;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rom_info[0] <= '0;
         rom_info[1] <= '0;
         rom_update  <= 1'b0;
      end else begin
         rom_update <= cart_end | eject_rise;
         if (eject_rise) begin
            rom_info[0] <= '0;
            rom_info[1] <= '0;
         end else if (cart_end) begin
            rom_info[index_q[1]].loaded <= 1'b1;   // index 1 -> 0, 2 -> 1.
            rom_info[index_q[1]].size   <= last_addr + 27'd1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/msx_pkg.sv ====
`default_nettype none

package msx_pkg;

   // **************************************************
   // machine side tables
   // **************************************************

   // one entry of the memory block table.
   typedef struct packed {
      logic        valid;
      logic        ram;
      logic [11:0] sdram_page;   // base, in pages.
      logic [7:0]  size_pages;
   } block_t;

   // one primary slot.
   // page_block[n] is the block id seen in 16 KB page n.
   typedef struct packed {
      logic            expanded;
      logic [3:0][3:0] page_block;
   } slot_t;

   // one cartridge slot.
   typedef struct packed {
      logic        loaded;
      logic [26:0] size;   // bytes.
   } rom_info_t;

endpackage

`default_nettype wire

// ==== verif/download_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module download_assertions (
   input logic clk,
   input logic rst,
   input logic ddr3_rd,
   input logic ddr3_request,
   input logic ddr3_ready,
   input logic sdram_we,
   input logic sdram_request,
   input logic need_reset
);

   logic rd_open;   // read issued, ready not yet seen.

   always_ff @(posedge clk) begin
      if (rst) rd_open <= 1'b0;
      else if (ddr3_rd) rd_open <= 1'b1;
      else if (ddr3_ready) rd_open <= 1'b0;
   end

   // **************************************************
   // port rules
   // **************************************************

   rd_in_request: assert property (@(posedge clk) disable iff (rst) ddr3_rd |-> ddr3_request)
      else $error("ddr3_rd asserted while ddr3_request is low");

   we_in_request: assert property (@(posedge clk) disable iff (rst) sdram_we |-> sdram_request)
      else $error("sdram_we asserted while sdram_request is low");

   one_read_open: assert property (@(posedge clk) disable iff (rst) ddr3_rd |-> !rd_open)
      else $error("second ddr3_rd issued before ddr3_ready");

   reset_is_pulse: assert property (@(posedge clk) disable iff (rst) need_reset |=> !need_reset)
      else $error("need_reset held longer than one cycle");

endmodule

bind download download_assertions download_assertions_inst (
   .clk           (clk),
   .rst           (rst),
   .ddr3_rd       (ddr3_rd),
   .ddr3_request  (ddr3_request),
   .ddr3_ready    (ddr3_ready),
   .sdram_we      (sdram_we),
   .sdram_request (sdram_request),
   .need_reset    (need_reset)
);

`default_nettype wire

// ==== verif/download_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dl_macros.svh"

module download_tb;

   import dl_pkg::*;
   import msx_pkg::*;

   logic        clk            = 1'b0;
   logic        rst            = 1'b1;
   logic        ioctl_download = 1'b0;
   logic [15:0] ioctl_index    = '0;
   logic [26:0] ioctl_addr     = '0;
   logic        rom_eject      = 1'b0;
   logic [7:0]  ddr3_dout      = '0;
   logic        ddr3_ready     = 1'b0;
   logic        sdram_ready    = 1'b0;
   logic [27:0] ddr3_addr;
   logic        ddr3_rd;
   logic        ddr3_request;
   logic        sdram_request;
   logic [24:0] sdram_addr;
   logic [7:0]  sdram_din;
   logic        sdram_we;
   block_t      memory_block [`MAX_MEM_BLOCK];
   slot_t       msx_slot [4];
   rom_info_t   rom_info [2];
   logic [1:0]  msx_type;
   logic [7:0]  ram_block_count;
   logic        need_reset;

   logic [7:0]  ddr3_mem [logic [27:0]];   // config image only.
   logic [7:0]  sdram_mem [logic [24:0]];
   logic [7:0]  exp_sdram [logic [24:0]];
   msx_config_u cfg_rec [$];
   block_t      exp_block [`MAX_MEM_BLOCK];
   slot_t       exp_slot [4];
   rom_info_t   exp_rom [2];
   logic [1:0]  exp_type = '0;
   logic [7:0]  exp_ram  = '0;
   logic [27:0] rd_addr  = '0;
   int          rd_wait  = 0;
   int          wr_wait  = 0;
   int          builds   = 0;
   int          cycles   = 0;
   int          cycle_limit = 2000;   // base margin.

   always #4 clk = ~clk;

   download download_inst (.*);

   // **************************************************
   // checks
   // **************************************************

   task automatic stop_failed();
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic check_block(input string name, input block_t got, input block_t exp);
      if (got !== exp) begin
         $display("error %s got %h expected %h", name, got, exp);
         stop_failed();
      end
   endtask

   task automatic check_slot(input string name, input slot_t got, input slot_t exp);
      if (got !== exp) begin
         $display("error %s got %h expected %h", name, got, exp);
         stop_failed();
      end
   endtask

   task automatic check_rom(input string name, input rom_info_t got, input rom_info_t exp);
      if (got !== exp) begin
         $display("error %s got %h expected %h", name, got, exp);
         stop_failed();
      end
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("error %s got %h expected %h", name, got, exp);
         stop_failed();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("error %s got %h expected %h", name, got, exp);
         stop_failed();
      end
   endtask

   // staged rom contents.
   function automatic logic [7:0] ddr3_byte(input logic [27:0] addr);
      if (ddr3_mem.exists(addr)) return ddr3_mem[addr];
      return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ {4'ha, addr[27:24]};
   endfunction

   function automatic msx_config_u make_block(input logic ram, input logic [3:0] id,
                                              input logic [9:0] src, input logic [7:0] size);
      msx_config_u r;
      r.block = '{kind: 1'b1, ram: ram, block_id: id, src_page: src, size_pages: size,
                  reserved: 8'h00};
      return r;
   endfunction

   function automatic msx_config_u make_slot(input logic [1:0] slot, input logic [1:0] sub,
                                             input logic exp, input logic [15:0] pages);
      msx_config_u r;
      r.slot = '{kind: 1'b0, slot: slot, subslot: sub, expanded: exp, page_block: pages,
                 reserved: 10'h000};
      return r;
   endfunction

   // expected tables and sdram image from the records.
   function automatic void build_expected();
      cfg_block_t b;
      cfg_slot_t  s;
      int         page;
      page    = 0;
      exp_ram = '0;
      exp_sdram.delete();
      for (int i = 0; i < `MAX_MEM_BLOCK; i++) exp_block[i] = '0;
      for (int i = 0; i < 4; i++) exp_slot[i] = '0;
      foreach (cfg_rec[k]) begin
         if (cfg_rec[k].block.kind) begin
            b = cfg_rec[k].block;
            exp_block[b.block_id] = '{valid: 1'b1, ram: b.ram, sdram_page: 12'(page),
                                      size_pages: b.size_pages};
            if (b.ram) begin
               exp_ram = exp_ram + 8'd1;
            end else begin
               for (int j = 0; j < int'(b.size_pages) * `PAGE_BYTES; j++)
                  exp_sdram[25'(page * `PAGE_BYTES + j)] =
                     ddr3_byte(28'(`ROM_BASE + int'(b.src_page) * `PAGE_BYTES + j));
            end
            page += int'(b.size_pages);
         end else begin
            s = cfg_rec[k].slot;
            exp_slot[s.slot] = '{expanded: s.expanded, page_block: s.page_block};
         end
      end
   endfunction

   task automatic compare_tables();
      check_byte("msx_type", 8'(msx_type), 8'(exp_type));
      check_byte("ram_block_count", ram_block_count, exp_ram);
      for (int i = 0; i < `MAX_MEM_BLOCK; i++)
         check_block($sformatf("memory_block[%0d]", i), memory_block[i], exp_block[i]);
      for (int i = 0; i < 4; i++)
         check_slot($sformatf("msx_slot[%0d]", i), msx_slot[i], exp_slot[i]);
      for (int i = 0; i < 2; i++)
         check_rom($sformatf("rom_info[%0d]", i), rom_info[i], exp_rom[i]);
      if (sdram_mem.num() != exp_sdram.num()) begin
         $display("SDRAM got %0d written bytes but %0d were expected",
                  sdram_mem.num(), exp_sdram.num());
         stop_failed();
      end
      foreach (exp_sdram[a]) begin
         if (!sdram_mem.exists(a)) begin
            $display("no SDRAM write reached address %h", a);
            stop_failed();
         end else begin
            check_byte($sformatf("sdram[%h]", a), sdram_mem[a], exp_sdram[a]);
         end
      end
   endtask

   // **************************************************
   // memory models
   // **************************************************

   always @(posedge clk) begin
      ddr3_ready <= 1'b0;
      if (ddr3_rd) begin
         rd_addr <= ddr3_addr;
         rd_wait <= 1 + int'($urandom % 6);
      end else if (rd_wait == 1) begin
         ddr3_dout  <= ddr3_byte(rd_addr);
         ddr3_ready <= 1'b1;
         rd_wait    <= 0;
      end else if (rd_wait > 1) begin
         rd_wait <= rd_wait - 1;
      end
   end

   always @(posedge clk) begin
      sdram_ready <= 1'b0;
      if (sdram_we) begin
         sdram_mem[sdram_addr] = sdram_din;
         wr_wait <= 1 + int'($urandom % 4);
      end else if (wr_wait == 1) begin
         sdram_ready <= 1'b1;
         wr_wait     <= 0;
      end else if (wr_wait > 1) begin
         wr_wait <= wr_wait - 1;
      end
   end

   // tables are stable while need_reset is high.
   always @(posedge clk) begin
      if (!rst && need_reset) begin
         compare_tables();
         sdram_mem.delete();   // next build starts empty.
         builds <= builds + 1;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout after %0d cycles, need_reset never came", cycles);
         stop_failed();
      end
   end

   // **************************************************
   // stimulus
   // **************************************************

   task automatic load_config(input logic [1:0] mtype, input int runs);
      config_hdr_t hdr;
      logic [31:0] word;
      hdr = '{spare: 1'b0, count: 5'(cfg_rec.size()), msx_type: mtype};
      ddr3_mem[`CONFIG_BASE] = hdr;
      foreach (cfg_rec[k]) begin
         word = cfg_rec[k];
         for (int b = 0; b < 4; b++)
            ddr3_mem[28'(`CONFIG_BASE + 1 + 4 * k + b)] = word[8 * b +: 8];   // little endian.
      end
      build_expected();
      exp_type = mtype;
      cycle_limit += 12 * (runs * exp_sdram.num() + 1 + 4 * cfg_rec.size());
   endtask

   task automatic run_download(input logic [15:0] index, input logic [26:0] last);
      @(posedge clk);
      ioctl_index    <= index;
      ioctl_addr     <= last - 27'd1;
      ioctl_download <= 1'b1;
      @(posedge clk);
      ioctl_addr <= last;
      @(posedge clk);
      ioctl_download <= 1'b0;
      @(posedge clk);
      ioctl_addr <= '0;
   endtask

   task automatic wait_build();
      int start;
      start = builds;
      while (builds == start) @(posedge clk);
   endtask

   initial begin
      void'($urandom(28));
      exp_rom[0] = '0;
      exp_rom[1] = '0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      check_flag("ddr3_request", ddr3_request, 1'b0);
      check_flag("ddr3_rd", ddr3_rd, 1'b0);
      check_flag("sdram_request", sdram_request, 1'b0);
      check_flag("sdram_we", sdram_we, 1'b0);
      check_flag("need_reset", need_reset, 1'b0);
      check_byte("msx_type", 8'(msx_type), 8'h00);
      check_byte("ram_block_count", ram_block_count, 8'h00);

      // two rom blocks, one ram block, two slots.
      cfg_rec.push_back(make_block(1'b0, 4'd1, 10'd0, 8'd2));
      cfg_rec.push_back(make_block(1'b1, 4'd2, 10'd0, 8'd4));
      cfg_rec.push_back(make_block(1'b0, 4'd3, 10'd5, 8'd1));
      cfg_rec.push_back(make_slot(2'd0, 2'd0, 1'b0, 16'h3211));
      cfg_rec.push_back(make_slot(2'd3, 2'd1, 1'b1, 16'h0220));
      load_config(2'd1, 3);
      run_download(16'd0, 27'd255);
      wait_build();

      exp_rom[1] = '{loaded: 1'b1, size: 27'h4000};   // cartridge b.
      run_download(16'd2, 27'h3fff);
      wait_build();

      exp_rom[0] = '0;
      exp_rom[1] = '0;
      @(posedge clk);
      rom_eject <= 1'b1;
      @(posedge clk);
      rom_eject <= 1'b0;
      wait_build();

      cfg_rec.delete();
      cfg_rec.push_back(make_block(1'b1, 4'd0, 10'd0, 8'd2));
      cfg_rec.push_back(make_block(1'b0, 4'd4, 10'd3, 8'd1));
      cfg_rec.push_back(make_slot(2'd1, 2'd0, 1'b0, 16'h4400));
      load_config(2'd2, 1);
      run_download(16'd0, 27'd255);
      wait_build();

      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire
